// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_regfile
FILELIST  := sim.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/regfile_2w6r.sv ====
`timescale 1ns/10ps

module regfile_2w6r #(
	parameter int NUM_READ = 6
) (
	input  logic                                   clka,
	input  logic                                   rst,
	input  rf_port_pkg::wr_req_t                   wr0,
	input  rf_port_pkg::wr_req_t                   wr1,
	input  rf_data_pkg::reg_addr_t [NUM_READ-1:0]  rd_addr,
	output rf_data_pkg::data_t     [NUM_READ-1:0]  rd_data
);

	import rf_data_pkg::*;
	import rf_port_pkg::*;

	data_t     [NUM_READ-1:0]                 bank0_word;
	data_t     [NUM_READ-1:0]                 bank1_word;
	bank_sel_e [NUM_READ-1:0][DATA_BYTES-1:0] live_tag;
	reg_addr_t [NUM_READ-1:0]                 live_addr_q;

	// ==================================================================
	// storage
	// ==================================================================

	// one bank per write port so both writes land in the same cycle
	rf_bank #(
		.NUM_READ (NUM_READ)
	) u_bank0 (
		.clka      (clka),
		.rst       (rst),
		.wr        (wr0),
		.rd_addr   (rd_addr),
		.rd_word   (bank0_word),
		.rd_addr_q ()
	);

	rf_bank #(
		.NUM_READ (NUM_READ)
	) u_bank1 (
		.clka      (clka),
		.rst       (rst),
		.wr        (wr1),
		.rd_addr   (rd_addr),
		.rd_word   (bank1_word),
		.rd_addr_q ()
	);

	// the live table also supplies the registered address used for
	// the register zero check
	rf_live_table #(
		.NUM_READ (NUM_READ)
	) u_live (
		.clka      (clka),
		.rst       (rst),
		.wr0       (wr0),
		.wr1       (wr1),
		.rd_addr   (rd_addr),
		.rd_tag    (live_tag),
		.rd_addr_q (live_addr_q)
	);

	// ==================================================================
	// read ports
	// ==================================================================

	for (genvar p = 0; p < NUM_READ; p++) begin : g_rd
		rf_read_select u_sel (
			.tag     (live_tag[p]),
			.addr_q  (live_addr_q[p]),
			.word0   (bank0_word[p]),
			.word1   (bank1_word[p]),
			.rd_data (rd_data[p])
		);
	end

endmodule

// ==== design/rf_bank.sv ====
`timescale 1ns/10ps

module rf_bank #(
	parameter int NUM_READ = 6
) (
	input  logic                                   clka,
	input  logic                                   rst,
	input  rf_port_pkg::wr_req_t                   wr,
	input  rf_data_pkg::reg_addr_t [NUM_READ-1:0]  rd_addr,
	output rf_data_pkg::data_t     [NUM_READ-1:0]  rd_word,
	output rf_data_pkg::reg_addr_t [NUM_READ-1:0]  rd_addr_q
);

	import rf_data_pkg::*;

	localparam int NUM_ENTRIES = 1 << REG_ADDR_W;

	// one word per register of every set
	data_t mem [0:NUM_ENTRIES-1];

	// ==================================================================
	// write side
	// ==================================================================

	// each byte lane has its own enable so partial writes leave the
	// other lanes untouched
	always_ff @(posedge clka) begin
		for (int b = 0; b < DATA_BYTES; b++) begin
			if (wr.we && wr.byte_en[b]) begin
				mem[wr.addr][b*8 +: 8] <= wr.data[b*8 +: 8];
			end
		end
	end

	// ==================================================================
	// read side
	// ==================================================================

	// read addresses are captured at the same edge that performs the
	// write, so the lookup below already sees the updated array
	always_ff @(posedge clka) begin
		if (rst) begin
			rd_addr_q <= '0;
		end else begin
			rd_addr_q <= rd_addr;
		end
	end

	always_comb begin
		for (int p = 0; p < NUM_READ; p++) begin
			rd_word[p] = mem[rd_addr_q[p]];
		end
	end

endmodule

// ==== design/rf_data_pkg.sv ====
// ======================================================================
// register word and register address definitions
// ======================================================================

package rf_data_pkg;

	// a register word is eight bytes wide
	localparam int DATA_BYTES = 8;

	typedef logic [DATA_BYTES*8-1:0] data_t;

	// one write enable per byte of a word
	typedef logic [DATA_BYTES-1:0] byte_en_t;

	// 8 register sets of 32 registers give 256 entries
	localparam int REG_ADDR_W = 8;

	// the register number sits in the low bits of the address
	// and the register set takes the bits above it
	localparam int REG_NUM_W = 5;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

// ==== design/rf_live_table.sv ====
`timescale 1ns/10ps

module rf_live_table #(
	parameter int NUM_READ = 6
) (
	input  logic                                   clka,
	input  logic                                   rst,
	input  rf_port_pkg::wr_req_t                   wr0,
	input  rf_port_pkg::wr_req_t                   wr1,
	input  rf_data_pkg::reg_addr_t [NUM_READ-1:0]  rd_addr,
	output rf_port_pkg::bank_sel_e [NUM_READ-1:0][rf_data_pkg::DATA_BYTES-1:0] rd_tag,
	output rf_data_pkg::reg_addr_t [NUM_READ-1:0]  rd_addr_q
);

	import rf_data_pkg::*;
	import rf_port_pkg::*;

	localparam int NUM_ENTRIES = 1 << REG_ADDR_W;

	// one bank tag per byte of every entry
	bank_sel_e [DATA_BYTES-1:0] tag_mem [0:NUM_ENTRIES-1];

	// ==================================================================
	// tag update
	// ==================================================================

	// port 0 is applied first and port 1 second, so when both ports
	// hit the same byte of the same entry the port 1 tag is kept
	always_ff @(posedge clka) begin
		if (rst) begin
			for (int e = 0; e < NUM_ENTRIES; e++) begin
				tag_mem[e] <= {DATA_BYTES{BANK_W0}};
			end
		end else begin
			for (int b = 0; b < DATA_BYTES; b++) begin
				if (wr0.we && wr0.byte_en[b]) begin
					tag_mem[wr0.addr][b] <= BANK_W0;
				end
				if (wr1.we && wr1.byte_en[b]) begin
					tag_mem[wr1.addr][b] <= BANK_W1;
				end
			end
		end
	end

	// ==================================================================
	// tag lookup
	// ==================================================================

	// registered like the bank addresses so the tags and the bank
	// words line up in the same cycle
	always_ff @(posedge clka) begin
		if (rst) begin
			rd_addr_q <= '0;
		end else begin
			rd_addr_q <= rd_addr;
		end
	end

	always_comb begin
		for (int p = 0; p < NUM_READ; p++) begin
			rd_tag[p] = tag_mem[rd_addr_q[p]];
		end
	end

endmodule

// ==== design/rf_port_pkg.sv ====
// ======================================================================
// write port request and bank tag definitions
// ======================================================================

package rf_port_pkg;

	// one write request as it arrives from the issue side
	// we is a plain strobe with no handshake behind it
	typedef struct packed {
		logic                 we;
		rf_data_pkg::byte_en_t byte_en;
		rf_data_pkg::reg_addr_t addr;
		rf_data_pkg::data_t    data;
	} wr_req_t;

	// names the bank that holds the newest copy of a byte
	// bank 0 is written by write port 0 and bank 1 by write port 1
	typedef enum logic {
		BANK_W0 = 1'b0,
		BANK_W1 = 1'b1
	} bank_sel_e;

	// the live table stores a full vector of these per entry
	// so a word can be assembled from both banks

endpackage

// ==== design/rf_read_select.sv ====
`timescale 1ns/10ps

module rf_read_select (
	input  rf_port_pkg::bank_sel_e [rf_data_pkg::DATA_BYTES-1:0] tag,
	input  rf_data_pkg::reg_addr_t                               addr_q,
	input  rf_data_pkg::data_t                                   word0,
	input  rf_data_pkg::data_t                                   word1,
	output rf_data_pkg::data_t                                   rd_data
);

	import rf_data_pkg::*;
	import rf_port_pkg::*;

	logic is_zero_reg;

	// register zero of every set is hardwired to zero whatever the
	// banks happen to hold at that entry
	assign is_zero_reg = (addr_q[REG_NUM_W-1:0] == '0);

	always_comb begin
		rd_data = '0;
		if (!is_zero_reg) begin
			// each byte comes from the bank that wrote it last
			for (int b = 0; b < DATA_BYTES; b++) begin
				if (tag[b] == BANK_W1) begin
					rd_data[b*8 +: 8] = word1[b*8 +: 8];
				end else begin
					rd_data[b*8 +: 8] = word0[b*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== sim.f ====
design/rf_data_pkg.sv
design/rf_port_pkg.sv
design/rf_bank.sv
design/rf_live_table.sv
design/rf_read_select.sv
design/regfile_2w6r.sv
testbench/regfile_chk.sv
testbench/tb_regfile.sv

// ==== testbench/regfile_chk.sv ====
`timescale 1ns/10ps

module regfile_chk #(
	parameter int NUM_READ = 6
) (
	input logic                                  clka,
	input logic                                  rst,
	input rf_data_pkg::reg_addr_t [NUM_READ-1:0] rd_addr,
	input rf_data_pkg::data_t     [NUM_READ-1:0] rd_data
);

	import rf_data_pkg::*;

	// ==================================================================
	// read port properties
	// ==================================================================

	// the registered addresses come out of reset at zero,
	// which is register zero of set zero
	a_reset_zero: assert property (@(posedge clka) $fell(rst) |-> (rd_data == '0))
		else $error("read data not zero in the first cycle after reset");

	for (genvar p = 0; p < NUM_READ; p++) begin : g_port
		a_zero_reg: assert property (@(posedge clka) disable iff (rst)
			(rd_addr[p][REG_NUM_W-1:0] == '0) |=> (rd_data[p] == '0))
			else $error("register zero on read port %0d returned nonzero data", p);

		// every pair of ports sees the same storage
		for (genvar q = p + 1; q < NUM_READ; q++) begin : g_pair
			a_same_addr: assert property (@(posedge clka) disable iff (rst)
				(rd_addr[p] == rd_addr[q]) |=> (rd_data[p] == rd_data[q]))
				else $error("read ports %0d and %0d disagree on one address", p, q);
		end
	end

endmodule

bind regfile_2w6r regfile_chk #(
	.NUM_READ (NUM_READ)
) u_chk (
	.clka    (clka),
	.rst     (rst),
	.rd_addr (rd_addr),
	.rd_data (rd_data)
);

// ==== testbench/tb_regfile.sv ====
`timescale 1ns/10ps

module tb_regfile;

	import rf_data_pkg::*;
	import rf_port_pkg::*;

	localparam int NUM_READ = 6;
	localparam int RESET_CYCLES = 16;

	// the directed tests need about 2550 cycles after reset, so the
	// limit sits near twice that
	localparam int TIMEOUT_CYCLES = 5000;

	localparam wr_req_t WR_IDLE = '0;

	typedef reg_addr_t [NUM_READ-1:0] addr_vec_t;

	logic                 clka;
	logic                 rst;
	wr_req_t              wr0;
	wr_req_t              wr1;
	addr_vec_t            rd_addr;
	data_t [NUM_READ-1:0] rd_data;

	// reference copy of every register as the writes should leave it
	data_t     model [0:(1 << REG_ADDR_W)-1];
	addr_vec_t cur_addr;
	int        cycle_count;

	regfile_2w6r #(
		.NUM_READ (NUM_READ)
	) UUT (
		.clka    (clka),
		.rst     (rst),
		.wr0     (wr0),
		.wr1     (wr1),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	initial begin
		clka = 1'b0;
		forever #4 clka = ~clka;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clka);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped by the cycle limit");
	end

	// ==================================================================
	// stimulus helpers
	// ==================================================================

	function automatic reg_addr_t make_addr(input int unsigned set, input int unsigned num);
		return reg_addr_t'((set << REG_NUM_W) | num);
	endfunction

	// any set, but never register zero of it
	function automatic reg_addr_t rand_reg();
		return make_addr($urandom_range(7, 0), $urandom_range(31, 1));
	endfunction

	function automatic data_t rand_word();
		return {$urandom(), $urandom()};
	endfunction

	function automatic wr_req_t make_wr(input reg_addr_t a, input byte_en_t en, input data_t d);
		wr_req_t w;
		w.we = 1'b1;
		w.byte_en = en;
		w.addr = a;
		w.data = d;
		return w;
	endfunction

	// even ports read a and odd ports read b
	function automatic addr_vec_t alt_addr(input reg_addr_t a, input reg_addr_t b);
		addr_vec_t v;
		for (int p = 0; p < NUM_READ; p++) begin
			v[p] = (p % 2 == 0) ? a : b;
		end
		return v;
	endfunction

	function automatic logic is_zero_reg(input reg_addr_t a);
		return a[REG_NUM_W-1:0] == '0;
	endfunction

	function automatic void apply_write(input wr_req_t w);
		for (int b = 0; b < DATA_BYTES; b++) begin
			if (w.we && w.byte_en[b]) begin
				model[w.addr][b*8 +: 8] = w.data[b*8 +: 8];
			end
		end
	endfunction

	// the writes land at the same edge that captures the addresses,
	// so the model takes them before the reads are checked
	task automatic step(input wr_req_t w0, input wr_req_t w1, input addr_vec_t addrs);
		@(posedge clka);
		wr0 <= w0;
		wr1 <= w1;
		rd_addr <= addrs;
		apply_write(w0);
		apply_write(w1);
		cur_addr = addrs;
	endtask

	// ==================================================================
	// compare tasks
	// ==================================================================

	task automatic compare_word(input string test_name, input int port,
			input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s port %0d expected %h actual %h",
				test_name, port, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "read data differs from the reference model");
		end
	endtask

	task automatic compare_tag_free_zero(input string test_name, input int port,
			input data_t actual);
		if (actual !== data_t'(0)) begin
			$display("MISMATCH %s port %0d expected %h actual %h",
				test_name, port, data_t'(0), actual);
			$display("TEST FAILED");
			$fatal(1, "register zero did not read as zero");
		end
	endtask

	task automatic check_reads(input string test_name);
		@(posedge clka);
		wr0 <= WR_IDLE;
		wr1 <= WR_IDLE;
		@(negedge clka);
		for (int p = 0; p < NUM_READ; p++) begin
			if (is_zero_reg(cur_addr[p])) begin
				compare_tag_free_zero(test_name, p, rd_data[p]);
			end else begin
				compare_word(test_name, p, model[cur_addr[p]], rd_data[p]);
			end
		end
	endtask

	// ==================================================================
	// directed tests
	// ==================================================================

	// the ports still point at unwritten registers here, so only the
	// reset of the address registers can make them read zero
	task automatic test_reset();
		@(negedge clka);
		for (int p = 0; p < NUM_READ; p++) begin
			compare_tag_free_zero("reset", p, rd_data[p]);
		end
		step(WR_IDLE, WR_IDLE, '0);
		check_reads("reset");
	endtask

	task automatic test_full_words();
		reg_addr_t a;
		reg_addr_t b;
		for (int i = 0; i < 150; i++) begin
			a = rand_reg();
			b = rand_reg();
			step(make_wr(a, '1, rand_word()), WR_IDLE, cur_addr);
			check_reads("full_words");
			step(WR_IDLE, make_wr(b, '1, rand_word()), cur_addr);
			check_reads("full_words");
			step(WR_IDLE, WR_IDLE, alt_addr(a, b));
			check_reads("full_words");
		end
	endtask

	task automatic test_partial_merge();
		reg_addr_t a;
		for (int i = 0; i < 100; i++) begin
			a = rand_reg();
			step(make_wr(a, '1, rand_word()), WR_IDLE, cur_addr);
			check_reads("partial_merge");
			step(WR_IDLE, make_wr(a, byte_en_t'($urandom()), rand_word()), cur_addr);
			check_reads("partial_merge");
			step(make_wr(a, byte_en_t'($urandom()), rand_word()), WR_IDLE, cur_addr);
			check_reads("partial_merge");
			step(WR_IDLE, WR_IDLE, alt_addr(a, a));
			check_reads("partial_merge");
		end
	endtask

	task automatic test_collision();
		reg_addr_t a;
		byte_en_t  shared;
		for (int i = 0; i < 100; i++) begin
			a = rand_reg();
			// at least one byte is enabled on both ports
			shared = byte_en_t'(1 << $urandom_range(7, 0));
			step(make_wr(a, '1, rand_word()), WR_IDLE, cur_addr);
			check_reads("collision");
			step(make_wr(a, byte_en_t'($urandom()) | shared, rand_word()),
				make_wr(a, byte_en_t'($urandom()) | shared, rand_word()), cur_addr);
			check_reads("collision");
			step(WR_IDLE, WR_IDLE, alt_addr(a, a));
			check_reads("collision");
		end
	endtask

	task automatic test_write_first();
		reg_addr_t a;
		reg_addr_t b;
		for (int i = 0; i < 50; i++) begin
			a = rand_reg();
			b = rand_reg();
			step(make_wr(a, '1, rand_word()), make_wr(b, '1, rand_word()), cur_addr);
			check_reads("write_first");
			step(make_wr(a, '1, rand_word()),
				make_wr(b, byte_en_t'($urandom()), rand_word()), alt_addr(a, b));
			check_reads("write_first");
		end
	endtask

	task automatic test_zero_reg();
		reg_addr_t z;
		reg_addr_t r1;
		reg_addr_t r2;
		addr_vec_t v;
		for (int s = 0; s < 8; s++) begin
			z = make_addr(s, 0);
			r1 = make_addr(s, 1);
			r2 = make_addr(s, 31);
			for (int p = 0; p < NUM_READ; p++) begin
				v[p] = (p % 3 == 0) ? z : ((p % 3 == 1) ? r1 : r2);
			end
			step(make_wr(z, '1, rand_word()), make_wr(r1, '1, rand_word()), cur_addr);
			check_reads("zero_reg");
			step(make_wr(r2, '1, rand_word()),
				make_wr(z, byte_en_t'($urandom()), rand_word()), v);
			check_reads("zero_reg");
			step(WR_IDLE, WR_IDLE, v);
			check_reads("zero_reg");
		end
	endtask

	initial begin
		void'($urandom(32'hbd00));
		rst = 1'b1;
		wr0 = WR_IDLE;
		wr1 = WR_IDLE;
		// each port aims at a different nonzero register during reset
		for (int p = 0; p < NUM_READ; p++) begin
			rd_addr[p] = make_addr(p, p + 1);
		end
		cur_addr = '0;
		repeat (RESET_CYCLES) @(posedge clka);
		rst <= 1'b0;
		test_reset();
		test_full_words();
		test_partial_merge();
		test_collision();
		test_write_first();
		test_zero_reg();
		$display("TEST OK");
		$finish;
	end

endmodule
